// File: delay_emulator.f
delay_pkg.sv
delay_regs.sv
drop_stage.sv
delay_stage.sv
delay_emulator.sv
tb_delay_emulator.sv

// File: delay_emulator.sv
`timescale 1ns/1ps
`default_nettype none

module delay_emulator #(
   parameter int ADDR_WIDTH = 32,
   parameter int FIFO_DEPTH = 8
) (
   input  wire                               ACLK,
   input  wire                               ARESETN,

   input  wire [ADDR_WIDTH-1:0]              awaddr,
   input  wire                               awvalid,
   output logic                              awready,
   input  wire [delay_pkg::REG_WIDTH-1:0]    wdata,
   input  wire [delay_pkg::STRB_WIDTH-1:0]   wstrb,
   input  wire                               wvalid,
   output logic                              wready,
   output delay_pkg::axi_resp_e              bresp,
   output logic                              bvalid,
   input  wire                               bready,
   input  wire [ADDR_WIDTH-1:0]              araddr,
   input  wire                               arvalid,
   output logic                              arready,
   output logic [delay_pkg::REG_WIDTH-1:0]   rdata,
   output delay_pkg::axi_resp_e              rresp,
   output logic                              rvalid,
   input  wire                               rready,

   input  wire                               in_req,
   input  wire delay_pkg::pkt_word_t         in_word,
   output logic                              in_ack,
   output logic                              out_req,
   output delay_pkg::pkt_word_t              out_word,
   input  wire                               out_ack
);

   logic [delay_pkg::REG_WIDTH-1:0] delay_length;
   logic [delay_pkg::REG_WIDTH-1:0] drop_loop;
   logic [delay_pkg::REG_WIDTH-1:0] drop_count;
   logic                            mid_req;
   logic                            mid_ack;
   delay_pkg::pkt_word_t            mid_word;

   delay_regs #(
      .ADDR_WIDTH (ADDR_WIDTH)
   ) u_regs (
      .ACLK         (ACLK),
      .ARESETN      (ARESETN),
      .awaddr       (awaddr),
      .awvalid      (awvalid),
      .awready      (awready),
      .wdata        (wdata),
      .wstrb        (wstrb),
      .wvalid       (wvalid),
      .wready       (wready),
      .bresp        (bresp),
      .bvalid       (bvalid),
      .bready       (bready),
      .araddr       (araddr),
      .arvalid      (arvalid),
      .arready      (arready),
      .rdata        (rdata),
      .rresp        (rresp),
      .rvalid       (rvalid),
      .rready       (rready),
      .delay_length (delay_length),
      .drop_loop    (drop_loop),
      .drop_count   (drop_count)
   );

   drop_stage u_drop (
      .ACLK       (ACLK),
      .ARESETN    (ARESETN),
      .drop_loop  (drop_loop),
      .drop_count (drop_count),
      .in_req     (in_req),
      .in_word    (in_word),
      .in_ack     (in_ack),
      .mid_req    (mid_req),
      .mid_word   (mid_word),
      .mid_ack    (mid_ack)
   );

   delay_stage #(
      .FIFO_DEPTH (FIFO_DEPTH)
   ) u_delay (
      .ACLK         (ACLK),
      .ARESETN      (ARESETN),
      .delay_length (delay_length),
      .mid_req      (mid_req),
      .mid_word     (mid_word),
      .mid_ack      (mid_ack),
      .out_req      (out_req),
      .out_word     (out_word),
      .out_ack      (out_ack)
   );

endmodule

`default_nettype wire

// File: delay_pkg.sv
`default_nettype none

package delay_pkg;

   localparam int WORD_WIDTH = 32;             // Stream payload
   localparam int REG_WIDTH  = 32;             // AXI-Lite data and register settings
   localparam int STRB_WIDTH = REG_WIDTH / 8;
   localparam int DEC_WIDTH  = 8;              // Low address bits that select a register

   // One word on a stream link
   typedef struct packed {
      logic [WORD_WIDTH-1:0] data;
      logic                  last;             // Final word of a packet
   } pkt_word_t;

   // Register map
   typedef enum logic [DEC_WIDTH-1:0] {
      REG_DELAY_LENGTH = 8'h00,                // Minimum age in cycles before release
      REG_DROP_LOOP    = 8'h01,                // Drop period in packets, 0 disables dropping
      REG_DROP_COUNT   = 8'h02                 // Packets dropped at the start of each period
   } reg_addr_e;

   typedef enum logic [1:0] {
      RESP_OKAY   = 2'b00,
      RESP_SLVERR = 2'b10
   } axi_resp_e;

endpackage

`default_nettype wire

// File: delay_regs.sv
`timescale 1ns/1ps
`default_nettype none

module delay_regs #(
   parameter int ADDR_WIDTH = 32
) (
   input  wire                               ACLK,
   input  wire                               ARESETN,

   input  wire [ADDR_WIDTH-1:0]              awaddr,
   input  wire                               awvalid,
   output logic                              awready,

   input  wire [delay_pkg::REG_WIDTH-1:0]    wdata,
   input  wire [delay_pkg::STRB_WIDTH-1:0]   wstrb,      // Writes always take the full word
   input  wire                               wvalid,
   output logic                              wready,

   output delay_pkg::axi_resp_e              bresp,
   output logic                              bvalid,
   input  wire                               bready,

   input  wire [ADDR_WIDTH-1:0]              araddr,
   input  wire                               arvalid,
   output logic                              arready,

   output logic [delay_pkg::REG_WIDTH-1:0]   rdata,
   output delay_pkg::axi_resp_e              rresp,
   output logic                              rvalid,
   input  wire                               rready,

   output logic [delay_pkg::REG_WIDTH-1:0]   delay_length,
   output logic [delay_pkg::REG_WIDTH-1:0]   drop_loop,
   output logic [delay_pkg::REG_WIDTH-1:0]   drop_count
);

   typedef enum logic [1:0] {
      WR_IDLE,
      WR_DATA,
      WR_RESP
   } wr_state_e;

   typedef enum logic {
      RD_IDLE,
      RD_RESP
   } rd_state_e;

   wr_state_e                       wr_state;
   rd_state_e                       rd_state;
   logic [delay_pkg::DEC_WIDTH-1:0] wr_addr;
   logic [delay_pkg::DEC_WIDTH-1:0] rd_addr;

   assign awready = (wr_state == WR_IDLE);
   assign wready  = (wr_state == WR_DATA);
   assign bvalid  = (wr_state == WR_RESP);
   assign arready = (rd_state == RD_IDLE);
   assign rvalid  = (rd_state == RD_RESP);

   // Only the decode bits of each address are kept
   always_ff @(posedge ACLK) begin
      if (awready && awvalid) begin
         wr_addr <= awaddr[delay_pkg::DEC_WIDTH-1:0];
      end
      if (arready && arvalid) begin
         rd_addr <= araddr[delay_pkg::DEC_WIDTH-1:0];
      end
   end

   // Write machine and register file
   always_ff @(posedge ACLK) begin
      if (!ARESETN) begin
         wr_state     <= WR_IDLE;
         bresp        <= delay_pkg::RESP_OKAY;
         delay_length <= '0;
         drop_loop    <= '0;
         drop_count   <= '0;
      end else begin
         case (wr_state)
            WR_IDLE: begin
               if (awvalid) begin
                  wr_state <= WR_DATA;
               end
            end
            WR_DATA: begin
               if (wvalid) begin
                  bresp    <= delay_pkg::RESP_OKAY;
                  wr_state <= WR_RESP;
                  case (wr_addr)
                     delay_pkg::REG_DELAY_LENGTH: delay_length <= wdata;
                     delay_pkg::REG_DROP_LOOP:    drop_loop    <= wdata;
                     delay_pkg::REG_DROP_COUNT:   drop_count   <= wdata;
                     default:                     bresp        <= delay_pkg::RESP_SLVERR;
                  endcase
               end
            end
            WR_RESP: begin
               if (bready) begin
                  wr_state <= WR_IDLE;
               end
            end
            default: wr_state <= WR_IDLE;
         endcase
      end
   end

   // Read machine
   always_ff @(posedge ACLK) begin
      if (!ARESETN) begin
         rd_state <= RD_IDLE;
      end else begin
         case (rd_state)
            RD_IDLE: begin
               if (arvalid) begin
                  rd_state <= RD_RESP;
               end
            end
            RD_RESP: begin
               if (rready) begin
                  rd_state <= RD_IDLE;
               end
            end
            default: rd_state <= RD_IDLE;
         endcase
      end
   end

   // Read data follows the latched address, unmapped reads return 0
   always_comb begin
      rdata = '0;
      rresp = delay_pkg::RESP_OKAY;
      case (rd_addr)
         delay_pkg::REG_DELAY_LENGTH: rdata = delay_length;
         delay_pkg::REG_DROP_LOOP:    rdata = drop_loop;
         delay_pkg::REG_DROP_COUNT:   rdata = drop_count;
         default:                     rresp = delay_pkg::RESP_SLVERR;
      endcase
   end

   // Responses are held until the master takes them
   assert property (@(posedge ACLK) disable iff (!ARESETN)
      bvalid && !bready |=> bvalid && $stable(bresp))
      else $error("bvalid dropped before bready");

   assert property (@(posedge ACLK) disable iff (!ARESETN)
      rvalid && !rready |=> rvalid && $stable(rdata) && $stable(rresp))
      else $error("rvalid dropped before rready");

endmodule

`default_nettype wire

// File: delay_stage.sv
`timescale 1ns/1ps
`default_nettype none

module delay_stage #(
   parameter int FIFO_DEPTH = 8
) (
   input  wire                               ACLK,
   input  wire                               ARESETN,

   input  wire [delay_pkg::REG_WIDTH-1:0]    delay_length,

   input  wire                               mid_req,
   input  wire delay_pkg::pkt_word_t         mid_word,
   output logic                              mid_ack,

   output logic                              out_req,
   output delay_pkg::pkt_word_t              out_word,
   input  wire                               out_ack
);

   localparam int PTR_WIDTH = $clog2(FIFO_DEPTH);

   typedef struct packed {
      delay_pkg::pkt_word_t            word;
      logic [delay_pkg::REG_WIDTH-1:0] stamp;    // Cycle of acceptance
   } entry_t;

   typedef enum logic {
      IN_IDLE,
      IN_ACK
   } in_state_e;

   typedef enum logic [1:0] {
      OUT_IDLE,
      OUT_REQ,
      OUT_WAIT
   } out_state_e;

   in_state_e                       in_state;
   out_state_e                      out_state;
   entry_t                          fifo_mem [FIFO_DEPTH];
   entry_t                          head;
   logic [PTR_WIDTH:0]              wr_ptr;
   logic [PTR_WIDTH:0]              rd_ptr;
   logic [PTR_WIDTH:0]              fill;
   logic [delay_pkg::REG_WIDTH-1:0] cycle_cnt;
   logic                            full;
   logic                            empty;
   logic                            fifo_wr;
   logic                            fifo_rd;
   logic                            head_ripe;

   assign fill  = wr_ptr - rd_ptr;
   assign empty = (wr_ptr == rd_ptr);
   assign full  = (wr_ptr[PTR_WIDTH] != rd_ptr[PTR_WIDTH]) &&
                  (wr_ptr[PTR_WIDTH-1:0] == rd_ptr[PTR_WIDTH-1:0]);

   assign head = fifo_mem[rd_ptr[PTR_WIDTH-1:0]];

   // Modulo subtraction keeps the age right across counter wrap
   assign head_ripe = !empty && ((cycle_cnt - head.stamp) >= delay_length);

   assign fifo_wr = (in_state == IN_IDLE) && mid_req && !full;    // Full withholds mid_ack
   assign fifo_rd = (out_state == OUT_IDLE) && head_ripe;

   assign mid_ack = (in_state == IN_ACK);
   assign out_req = (out_state == OUT_REQ);

   always_ff @(posedge ACLK) begin
      if (!ARESETN) begin
         cycle_cnt <= '0;
         wr_ptr    <= '0;
         rd_ptr    <= '0;
         in_state  <= IN_IDLE;
         out_state <= OUT_IDLE;
      end else begin
         cycle_cnt <= cycle_cnt + 1'b1;

         if (fifo_wr) begin
            wr_ptr <= wr_ptr + 1'b1;
         end
         if (fifo_rd) begin
            rd_ptr <= rd_ptr + 1'b1;
         end

         case (in_state)
            IN_IDLE: if (fifo_wr)  in_state <= IN_ACK;
            IN_ACK:  if (!mid_req) in_state <= IN_IDLE;
            default: in_state <= IN_IDLE;
         endcase

         case (out_state)
            OUT_IDLE: if (fifo_rd)  out_state <= OUT_REQ;
            OUT_REQ:  if (out_ack)  out_state <= OUT_WAIT;
            OUT_WAIT: if (!out_ack) out_state <= OUT_IDLE;
            default:  out_state <= OUT_IDLE;
         endcase
      end
   end

   always_ff @(posedge ACLK) begin
      if (fifo_wr) begin
         fifo_mem[wr_ptr[PTR_WIDTH-1:0]] <= '{word: mid_word, stamp: cycle_cnt};
      end
      if (fifo_rd) begin
         out_word <= head.word;       // Slot is freed as the word moves out
      end
   end

   // Occupancy above the depth means a write landed on a full FIFO
   assert property (@(posedge ACLK) disable iff (!ARESETN)
      fill <= FIFO_DEPTH)
      else $error("FIFO written while full");

   assert property (@(posedge ACLK) disable iff (!ARESETN)
      out_req && !out_ack |=> out_req && $stable(out_word))
      else $error("out_req dropped before out_ack");

endmodule

`default_nettype wire

// File: drop_stage.sv
`timescale 1ns/1ps
`default_nettype none

module drop_stage (
   input  wire                               ACLK,
   input  wire                               ARESETN,

   input  wire [delay_pkg::REG_WIDTH-1:0]    drop_loop,
   input  wire [delay_pkg::REG_WIDTH-1:0]    drop_count,

   input  wire                               in_req,
   input  wire delay_pkg::pkt_word_t         in_word,
   output logic                              in_ack,

   output logic                              mid_req,
   output delay_pkg::pkt_word_t              mid_word,
   input  wire                               mid_ack
);

   typedef enum logic [1:0] {
      ST_IDLE,
      ST_FORWARD,
      ST_ACK_UP,
      ST_ACK_DOWN
   } state_e;

   state_e                          state;
   logic [delay_pkg::REG_WIDTH-1:0] pkt_idx;       // Packet index within the drop period
   logic [delay_pkg::REG_WIDTH-1:0] pkt_idx_next;
   logic                            in_packet;     // Inside a packet, first word already taken
   logic                            drop_flag;     // Decision held for the current packet
   logic                            drop_start;
   logic                            drop_word;
   logic                            take;

   assign take       = (state == ST_IDLE) && in_req;
   assign drop_start = (drop_loop != '0) && (pkt_idx < drop_count);
   assign drop_word  = in_packet ? drop_flag : drop_start;

   // Wrap also covers a period shortened by a register write
   assign pkt_idx_next = ((pkt_idx + 1'b1) >= drop_loop) ? '0 : pkt_idx + 1'b1;

   assign in_ack  = (state == ST_ACK_UP);
   assign mid_req = (state == ST_FORWARD);

   always_ff @(posedge ACLK) begin
      if (!ARESETN) begin
         state     <= ST_IDLE;
         pkt_idx   <= '0;
         in_packet <= 1'b0;
         drop_flag <= 1'b0;
      end else begin
         if (take) begin
            if (!in_packet) begin
               drop_flag <= drop_start;
            end
            in_packet <= !in_word.last;
            if (in_word.last) begin
               pkt_idx <= pkt_idx_next;
            end
         end

         case (state)
            ST_IDLE: begin
               if (in_req) begin
                  state <= drop_word ? ST_ACK_UP : ST_FORWARD;   // Dropped words skip mid
               end
            end
            ST_FORWARD: begin
               if (mid_ack) begin
                  state <= ST_ACK_UP;
               end
            end
            ST_ACK_UP: begin
               if (!in_req) begin
                  state <= ST_ACK_DOWN;
               end
            end
            ST_ACK_DOWN: begin
               if (!mid_ack) begin
                  state <= ST_IDLE;                             // Mid link back to rest
               end
            end
            default: state <= ST_IDLE;
         endcase
      end
   end

   always_ff @(posedge ACLK) begin
      if (take && !drop_word) begin
         mid_word <= in_word;
      end
   end

   assert property (@(posedge ACLK) disable iff (!ARESETN)
      mid_req |=> !mid_req || $stable(mid_word))
      else $error("mid_word changed while mid_req high");

endmodule

`default_nettype wire

// File: tb_delay_emulator.sv
`timescale 1ns/1ps
`default_nettype none

module tb_delay_emulator;

   localparam int ADDR_WIDTH = 32;
   localparam int FIFO_DEPTH = 8;
   localparam int TIMEOUT    = 200;

   logic                   ACLK = 1'b0;
   logic                   ARESETN;
   logic [ADDR_WIDTH-1:0]  awaddr;
   logic                   awvalid;
   logic                   awready;
   logic [31:0]            wdata;
   logic [3:0]             wstrb;
   logic                   wvalid;
   logic                   wready;
   delay_pkg::axi_resp_e   bresp;
   logic                   bvalid;
   logic                   bready;
   logic [ADDR_WIDTH-1:0]  araddr;
   logic                   arvalid;
   logic                   arready;
   logic [31:0]            rdata;
   delay_pkg::axi_resp_e   rresp;
   logic                   rvalid;
   logic                   rready;
   logic                   in_req;
   delay_pkg::pkt_word_t   in_word;
   logic                   in_ack;
   logic                   out_req;
   delay_pkg::pkt_word_t   out_word;
   logic                   out_ack;

   delay_pkg::pkt_word_t   exp_q [$];       // Words the drop rule keeps in send order
   int unsigned            time_q [$];      // Cycle of each kept word's in_req
   int unsigned            cyc = 0;
   int unsigned            stall_until = 0; // Sink holds off acks before this cycle
   int unsigned            pkt_num = 0;
   logic [31:0]            cfg_delay = 0;
   logic [31:0]            cfg_loop = 0;
   logic [31:0]            cfg_count = 0;
   int                     errors = 0;
   int                     timeouts = 0;

   delay_emulator #(
      .ADDR_WIDTH (ADDR_WIDTH),
      .FIFO_DEPTH (FIFO_DEPTH)
   ) u_dut (.*);

   always #50 ACLK = ~ACLK;

   always @(posedge ACLK) cyc <= cyc + 1;

   assert property (@(posedge ACLK) disable iff (!ARESETN)
      out_req && !out_ack |=> $stable(out_word))
      else begin
         errors++;
         $display("ERR out_word changed under out_req: was %h now %h", $past(out_word), out_word);
      end

   task automatic finish_run();
      $display("Check errors: %0d, timeouts: %0d", errors, timeouts);
      if (errors == 0 && timeouts == 0) begin
         $display("Done: no errors");
      end else begin
         $display("Done: errors found");
      end
      $finish;
   endtask

   task automatic report_timeout(input string what);
      timeouts++;
      $display("Gave up after %0d cycles waiting for %s", TIMEOUT, what);
      finish_run();
   endtask

   task automatic expect_equal(input string name, input logic [63:0] got, input logic [63:0] exp);
      assert (got === exp) else begin
         errors++;
         $display("ERR %s got %h expected %h", name, got, exp);
      end
   endtask

   task automatic axi_write(input logic [31:0] addr, input logic [31:0] data,
                            output delay_pkg::axi_resp_e resp);
      int n;
      @(negedge ACLK);
      awaddr  = addr;
      awvalid = 1'b1;
      for (n = 0; n < TIMEOUT && !awready; n++) @(negedge ACLK);
      if (!awready) report_timeout("awready");
      @(negedge ACLK);                      // Address taken at the edge in between
      awvalid = 1'b0;
      wdata   = data;
      wvalid  = 1'b1;
      for (n = 0; n < TIMEOUT && !wready; n++) @(negedge ACLK);
      if (!wready) report_timeout("wready");
      @(negedge ACLK);
      wvalid = 1'b0;
      bready = 1'b1;
      for (n = 0; n < TIMEOUT && !bvalid; n++) @(negedge ACLK);
      if (!bvalid) report_timeout("bvalid");
      resp = bresp;
      @(negedge ACLK);
      bready = 1'b0;
   endtask

   task automatic axi_read(input logic [31:0] addr, output logic [31:0] data,
                           output delay_pkg::axi_resp_e resp);
      int n;
      @(negedge ACLK);
      araddr  = addr;
      arvalid = 1'b1;
      for (n = 0; n < TIMEOUT && !arready; n++) @(negedge ACLK);
      if (!arready) report_timeout("arready");
      @(negedge ACLK);
      arvalid = 1'b0;
      rready  = 1'b1;
      for (n = 0; n < TIMEOUT && !rvalid; n++) @(negedge ACLK);
      if (!rvalid) report_timeout("rvalid");
      data = rdata;
      resp = rresp;
      @(negedge ACLK);
      rready = 1'b0;
   endtask

   task automatic set_config(input logic [31:0] dly, input logic [31:0] loop,
                             input logic [31:0] count);
      delay_pkg::axi_resp_e resp;
      axi_write(32'h0, dly, resp);
      expect_equal("bresp", resp, delay_pkg::RESP_OKAY);
      axi_write(32'h1, loop, resp);
      expect_equal("bresp", resp, delay_pkg::RESP_OKAY);
      axi_write(32'h2, count, resp);
      expect_equal("bresp", resp, delay_pkg::RESP_OKAY);
      cfg_delay = dly;
      cfg_loop  = loop;
      cfg_count = count;
   endtask

   // Sends one packet of 1 to 4 random words and queues only the kept ones
   task automatic send_packet(output int len);
      delay_pkg::pkt_word_t w;
      logic keep;
      int i;
      int n;
      len  = $urandom_range(1, 4);
      keep = !(cfg_loop != 0 && (pkt_num % cfg_loop) < cfg_count);
      pkt_num++;
      for (i = 0; i < len; i++) begin
         @(negedge ACLK);
         w.data  = $urandom;
         w.last  = (i == len - 1);
         in_word = w;
         in_req  = 1'b1;
         if (keep) begin
            exp_q.push_back(w);
            time_q.push_back(cyc);
         end
         for (n = 0; n < TIMEOUT && !in_ack; n++) @(negedge ACLK);
         if (!in_ack) report_timeout("in_ack to rise");
         in_req = 1'b0;
         for (n = 0; n < TIMEOUT && in_ack; n++) @(negedge ACLK);
         if (in_ack) report_timeout("in_ack to fall");
      end
   endtask

   task automatic send_words(input int min_words);
      int sent;
      int len;
      sent = 0;
      while (sent < min_words) begin
         send_packet(len);
         sent += len;
      end
   endtask

   task automatic wait_drain();
      int n;
      for (n = 0; n < TIMEOUT && exp_q.size() != 0; n++) @(negedge ACLK);
      if (exp_q.size() != 0) report_timeout("expected words on out");
   endtask

   // Sink with random ack gaps that checks each word as its out_req rises
   initial begin : out_sink
      delay_pkg::pkt_word_t exp_w;
      int unsigned t_in;
      int unsigned gap;
      int n;
      out_ack = 1'b0;
      forever begin
         @(negedge ACLK);
         if (ARESETN && out_req && !out_ack) begin
            assert (exp_q.size() != 0) else begin
               errors++;
               $display("Word %h appeared on out when none was expected", out_word);
            end
            if (exp_q.size() != 0) begin
               exp_w = exp_q.pop_front();
               t_in  = time_q.pop_front();
               expect_equal("out_word", out_word, exp_w);
               assert (cyc - t_in >= 2 + cfg_delay) else begin
                  errors++;
                  $display("ERR out_req latency got %h minimum %h", cyc - t_in, 2 + cfg_delay);
               end
            end
            gap = $urandom_range(0, 3);
            repeat (gap) @(negedge ACLK);
            for (n = 0; n < TIMEOUT && cyc < stall_until; n++) @(negedge ACLK);
            out_ack = 1'b1;
            for (n = 0; n < TIMEOUT && out_req; n++) @(negedge ACLK);
            if (out_req) report_timeout("out_req to fall");
            out_ack = 1'b0;
         end
      end
   end

   initial begin : main
      logic [31:0] shadow [3];
      logic [31:0] data;
      delay_pkg::axi_resp_e resp;
      int i;
      void'($urandom(32'h3fc3e1be));
      ARESETN = 1'b0;
      awaddr  = '0;
      awvalid = 1'b0;
      wdata   = '0;
      wstrb   = 4'hf;
      wvalid  = 1'b0;
      bready  = 1'b0;
      araddr  = '0;
      arvalid = 1'b0;
      rready  = 1'b0;
      in_req  = 1'b0;
      in_word = '0;
      repeat (4) @(negedge ACLK);
      ARESETN = 1'b1;
      @(negedge ACLK);

      expect_equal("awready", awready, 1'b1);
      expect_equal("arready", arready, 1'b1);
      expect_equal("bvalid", bvalid, 1'b0);
      expect_equal("rvalid", rvalid, 1'b0);
      expect_equal("in_ack", in_ack, 1'b0);
      expect_equal("out_req", out_req, 1'b0);
      for (i = 0; i < 3; i++) begin
         axi_read(i, data, resp);
         expect_equal("rdata", data, 32'h0);
         expect_equal("rresp", resp, delay_pkg::RESP_OKAY);
      end

      for (i = 0; i < 3; i++) begin
         shadow[i] = $urandom;
         axi_write(i, shadow[i], resp);
         expect_equal("bresp", resp, delay_pkg::RESP_OKAY);
      end
      for (i = 0; i < 3; i++) begin
         axi_read(i, data, resp);
         expect_equal("rdata", data, shadow[i]);
         expect_equal("rresp", resp, delay_pkg::RESP_OKAY);
      end
      axi_write(32'h5, $urandom, resp);
      expect_equal("bresp", resp, delay_pkg::RESP_SLVERR);
      axi_read(32'h5, data, resp);
      expect_equal("rdata", data, 32'h0);
      expect_equal("rresp", resp, delay_pkg::RESP_SLVERR);
      for (i = 0; i < 3; i++) begin
         axi_read(i, data, resp);
         expect_equal("rdata", data, shadow[i]);
      end

      // Drop one packet of every three, then no dropping
      set_config(0, 3, 1);
      for (i = 0; i < 12; i++) send_packet(data);
      wait_drain();
      set_config(0, 0, 0);
      for (i = 0; i < 6; i++) send_packet(data);
      wait_drain();

      set_config(5, 0, 0);
      send_words(16);
      wait_drain();
      set_config(20, 0, 0);
      send_words(16);
      wait_drain();

      // Sink stalls while the FIFO overfills
      set_config(5, 0, 0);
      stall_until = cyc + 60;
      send_words(FIFO_DEPTH + 4);
      wait_drain();

      finish_run();
   end

endmodule

`default_nettype wire
